// File: eg_atten_out.sv
// output attenuation = level + tl*8, clamped to full silence
// att_o only changes with step_i, att_valid_o marks each update
`timescale 1ns/1ps
`default_nettype none

module eg_atten_out
	(
	input  wire                            mclk_i,
	input  wire                            arst_n_i,
	input  wire                            step_i,
	input  wire  [eg_pkg::EG_LEVEL_W-1:0]  level_i,
	input  wire  [6:0]                     tl_i,
	output logic [eg_pkg::EG_LEVEL_W-1:0]  att_o,
	output logic                           att_valid_o
	);

	logic [eg_pkg::EG_LEVEL_W:0] att_sum;
	logic [eg_pkg::EG_LEVEL_W-1:0] att_clamp;

	always_comb
	begin
		att_sum   = {1'b0, level_i} + {1'b0, tl_i, 3'b000};
		att_clamp = att_sum[eg_pkg::EG_LEVEL_W] ? eg_pkg::EG_LEVEL_MAX
			: att_sum[eg_pkg::EG_LEVEL_W-1:0];
	end

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			att_o       <= eg_pkg::EG_LEVEL_MAX;
			att_valid_o <= 1'b0;
		end
		else
		begin
			att_valid_o <= step_i;
			if (step_i)
				att_o <= att_clamp;
		end
	end

endmodule

`default_nettype wire

// File: eg_env_state.sv
// ADSR state and 10-bit level, updated on the clock edge that samples step_i
// steps are ignored while the rate stage still carries the previous state's rate
`timescale 1ns/1ps
`default_nettype none

module eg_env_state
	(
	input  wire                            mclk_i,
	input  wire                            arst_n_i,
	input  wire                            key_on_i,
	input  wire                            step_i,
	input  eg_pkg::eg_amount_t             amount_i,
	input  wire  [eg_pkg::EG_EFF_W-1:0]    eff_rate_i,
	input  wire  [eg_pkg::EG_RATE_W-1:0]   sl_i,
	output eg_pkg::eg_state_t              state_o,
	output logic [eg_pkg::EG_LEVEL_W-1:0]  level_o
	);

	eg_pkg::eg_state_t state_q;
	eg_pkg::eg_state_t state_d1;
	eg_pkg::eg_state_t state_nxt;
	logic [eg_pkg::EG_LEVEL_W-1:0] level_q;
	logic [eg_pkg::EG_LEVEL_W-1:0] level_nxt;
	logic [eg_pkg::EG_LEVEL_W-1:0] att_dec;
	logic [eg_pkg::EG_LEVEL_W-1:0] lin_level;
	logic [eg_pkg::EG_LEVEL_W:0] lin_sum;
	logic key_q;
	logic key_rise;
	logic key_fall;
	logic rate_ok;

	always_comb
	begin
		key_rise = key_on_i & ~key_q;
		key_fall = ~key_on_i & key_q;
		rate_ok  = (state_q == state_d1); // eff_rate_i matches state_q

		// attack curve, larger steps near full volume are smaller in absolute terms
		att_dec = (level_q >> (3'd5 - amount_i)) + 1'b1;

		lin_sum   = {1'b0, level_q} + (eg_pkg::EG_LEVEL_W + 1)'(amount_i);
		lin_level = lin_sum[eg_pkg::EG_LEVEL_W] ? eg_pkg::EG_LEVEL_MAX
			: lin_sum[eg_pkg::EG_LEVEL_W-1:0];

		state_nxt = state_q;
		level_nxt = level_q;

		if (key_rise)
			state_nxt = eg_pkg::ATTACK;
		else if (key_fall)
			state_nxt = eg_pkg::RELEASE;
		else if (step_i && rate_ok)
		begin
			case (state_q)
				eg_pkg::ATTACK:
				begin
					if (eff_rate_i >= eg_pkg::EG_INSTANT_RATE)
						level_nxt = '0; // instant attack
					else if (amount_i != '0)
						level_nxt = (level_q > att_dec) ? level_q - att_dec : '0;
					if (level_nxt == '0)
						state_nxt = eg_pkg::DECAY;
				end
				eg_pkg::DECAY:
				begin
					level_nxt = lin_level;
					if (lin_level[9:5] >= sl_i)
						state_nxt = eg_pkg::SUSTAIN;
				end
				default:
					level_nxt = lin_level; // sustain and release
			endcase
		end
	end

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			key_q    <= 1'b0;
			state_q  <= eg_pkg::RELEASE;
			state_d1 <= eg_pkg::RELEASE;
			level_q  <= eg_pkg::EG_LEVEL_MAX;
		end
		else
		begin
			key_q    <= key_on_i;
			state_q  <= state_nxt;
			state_d1 <= state_q;
			level_q  <= level_nxt;
		end
	end

	assign state_o = state_q;
	assign level_o = level_q;

	level_needs_step: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		!step_i |=> $stable(level_o))
		else $error("level changed without a step");

	level_falls_in_attack: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		(level_o < $past(level_o)) |-> ($past(state_o) == eg_pkg::ATTACK))
		else $error("level fell outside ATTACK");

endmodule

`default_nettype wire

// File: eg_inc.sv
// step_o follows every tick and amount_o is zero on ticks that skip
// slow rates step only when the counter shift is large enough and fast rates step every tick
`timescale 1ns/1ps
`default_nettype none

module eg_inc
	(
	input  wire                          mclk_i,
	input  wire                          arst_n_i,
	input  wire                          tick_i,
	input  wire  [3:0]                   cnt_shift_i,
	input  wire  [1:0]                   cnt_phase_i,
	input  wire  [eg_pkg::EG_EFF_W-1:0]  eff_rate_i,
	output logic                         step_o,
	output eg_pkg::eg_amount_t           amount_o
	);

	localparam logic [3:0] FAST_HI = 4'(eg_pkg::EG_FAST_RATE >> 2);

	logic [3:0] rate_hi;
	logic [4:0] shift_sum;
	logic tbl_bit;
	eg_pkg::eg_amount_t amount;

	always_comb
	begin
		rate_hi   = eff_rate_i[5:2];
		tbl_bit   = eg_pkg::eg_step_tbl[eff_rate_i[1:0]][cnt_phase_i];
		shift_sum = {1'b0, cnt_shift_i} + {1'b0, rate_hi};

		if (eff_rate_i == '0)
			amount = '0;
		else if (rate_hi < FAST_HI)
		begin
			// slow rates wait for enough counter zeros
			if (shift_sum >= 5'(eg_pkg::EG_CNT_W - 1))
				amount = eg_pkg::eg_amount_t'(tbl_bit);
			else
				amount = '0;
		end
		else
			amount = eg_pkg::eg_amount_t'(tbl_bit) + eg_pkg::eg_amount_t'(rate_hi - FAST_HI);
	end

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			step_o   <= 1'b0;
			amount_o <= '0;
		end
		else
		begin
			step_o   <= tick_i;
			amount_o <= tick_i ? amount : '0;
		end
	end

	amount_legal: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		step_o ? (amount_o <= 3'd4) : (amount_o == '0))
		else $error("amount_o out of range or nonzero without step_o");

endmodule

`default_nettype wire

// File: eg_pkg.sv
// shared widths, state encoding and step pattern for the single-operator envelope generator
// step table rows are indexed by effective rate bits [1:0], columns by counter phase
`default_nettype none

package eg_pkg;

	localparam int EG_LEVEL_W      = 10;
	localparam logic [EG_LEVEL_W-1:0] EG_LEVEL_MAX = 10'h3ff; // full silence
	localparam int EG_RATE_W       = 5;  // ar, dr, sr, sl
	localparam int EG_EFF_W        = 6;
	localparam int EG_CNT_W        = 12;
	localparam int EG_TICK_DIV     = 3;  // clocks per envelope tick
	localparam int EG_INSTANT_RATE = 62;
	localparam int EG_FAST_RATE    = 48; // every tick steps from here up

	typedef enum logic [1:0]
	{
		ATTACK  = 2'd0,
		DECAY   = 2'd1,
		SUSTAIN = 2'd2,
		RELEASE = 2'd3
	} eg_state_t;

	typedef logic [2:0] eg_amount_t; // 0 to 4

	// bit p of a row is the step for counter phase p
	localparam logic [3:0] eg_step_tbl [4] = '{
		4'b0101, // rate % 4 == 0
		4'b0111,
		4'b1101,
		4'b1111
	};

endpackage

`default_nettype wire

// File: eg_rate.sv
// effective rate for the running state with key scaling, one register stage
// a zero register rate always gives effective rate 0, whatever the key code
`timescale 1ns/1ps
`default_nettype none

module eg_rate
	(
	input  wire                              mclk_i,
	input  wire                              arst_n_i,
	input  eg_pkg::eg_state_t                state_i,
	input  wire  [eg_pkg::EG_RATE_W-1:0]     ar_i,
	input  wire  [eg_pkg::EG_RATE_W-1:0]     dr_i,
	input  wire  [eg_pkg::EG_RATE_W-1:0]     sr_i,
	input  wire  [eg_pkg::EG_RATE_W-2:0]     rr_i,
	input  wire  [1:0]                       ks_i,
	input  wire  [4:0]                       kcode_i,
	output logic [eg_pkg::EG_EFF_W-1:0]      eff_rate_o
	);

	logic [eg_pkg::EG_RATE_W-1:0] sel_rate;
	logic [4:0] ks_add;
	logic [eg_pkg::EG_EFF_W:0] rate_sum;
	logic [eg_pkg::EG_EFF_W-1:0] eff_nxt;

	always_comb
	begin
		case (state_i)
			eg_pkg::ATTACK:  sel_rate = ar_i;
			eg_pkg::DECAY:   sel_rate = dr_i;
			eg_pkg::SUSTAIN: sel_rate = sr_i;
			default:         sel_rate = {rr_i, 1'b1}; // release rate is coarser
		endcase

		ks_add   = kcode_i >> (2'd3 - ks_i);
		rate_sum = {1'b0, sel_rate, 1'b0} + {2'b00, ks_add};

		if (sel_rate == '0)
			eff_nxt = '0;
		else if (rate_sum[eg_pkg::EG_EFF_W])
			eff_nxt = '1; // saturate at 63
		else
			eff_nxt = rate_sum[eg_pkg::EG_EFF_W-1:0];
	end

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			eff_rate_o <= '0;
		else
			eff_rate_o <= eff_nxt;
	end

endmodule

`default_nettype wire

// File: eg_timer.sv
// envelope tick every EG_TICK_DIV clocks, 12-bit global counter advanced per tick
// shift and phase describe the counter value after the increment, held until the next tick
`timescale 1ns/1ps
`default_nettype none

module eg_timer
	(
	input  wire       mclk_i,
	input  wire       arst_n_i,
	output logic      tick_o,
	output logic [3:0] cnt_shift_o,
	output logic [1:0] cnt_phase_o
	);

	localparam int DIV_W = $clog2(eg_pkg::EG_TICK_DIV);

	logic [DIV_W-1:0] div_q;
	logic [eg_pkg::EG_CNT_W-1:0] cnt_q;
	logic [eg_pkg::EG_CNT_W-1:0] cnt_nxt;
	logic [eg_pkg::EG_CNT_W-1:0] cnt_above;
	logic [3:0] shift_nxt;
	logic div_end;

	// lowest set bit position, zero counter reports the top position
	function automatic logic [3:0] trail_zeros(input logic [eg_pkg::EG_CNT_W-1:0] v);
		logic [3:0] n;
		n = 4'(eg_pkg::EG_CNT_W - 1);
		for (int i = eg_pkg::EG_CNT_W - 2; i >= 0; i--)
		begin
			if (v[i])
				n = 4'(i);
		end
		return n;
	endfunction

	always_comb
	begin
		div_end   = (div_q == DIV_W'(eg_pkg::EG_TICK_DIV - 1));
		cnt_nxt   = cnt_q + 1'b1;
		shift_nxt = trail_zeros(cnt_nxt);
		cnt_above = cnt_nxt >> (shift_nxt + 4'd1); // bits just above the lowest one
	end

	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			div_q       <= '0;
			cnt_q       <= '0;
			tick_o      <= 1'b0;
			cnt_shift_o <= 4'(eg_pkg::EG_CNT_W - 1);
			cnt_phase_o <= 2'd0;
		end
		else
		begin
			tick_o <= div_end;
			if (div_end)
			begin
				div_q       <= '0;
				cnt_q       <= cnt_nxt;
				cnt_shift_o <= shift_nxt;
				cnt_phase_o <= cnt_above[1:0];
			end
			else
				div_q <= div_q + 1'b1;
		end
	end

	tick_single: assert property (@(posedge mclk_i) disable iff (!arst_n_i)
		tick_o |=> !tick_o)
		else $error("tick_o held for two cycles");

endmodule

`default_nettype wire

// File: tb_eg_util.svh
// stimulus table, compare task and pulse wait for tb_ym_eg_top, included inside that module
// uses mclk, att, att_valid, errors, VALID_TIMEOUT and abort_run of the including module
`ifndef TB_EG_UTIL_SVH
`define TB_EG_UTIL_SVH

typedef enum logic [1:0] {cmp_eq, cmp_le, cmp_ge} cmp_t;
typedef enum logic [1:0] {tr_any, tr_flat, tr_up, tr_down} trend_t; // att_o from pulse to pulse

typedef struct packed
{
	logic              key_on;
	logic [4:0]        ar;
	logic [4:0]        dr;
	logic [4:0]        sr;
	logic [3:0]        rr;
	logic [4:0]        sl;
	logic [6:0]        tl;
	logic [1:0]        ks;
	logic [4:0]        kcode;
	logic [15:0]       pulses; // att_valid_o pulses before the final check
	eg_pkg::eg_state_t exp_state;
	cmp_t              att_cmp;
	logic [9:0]        att_exp;
	trend_t            trend;
} row_t;

localparam int NUM_ROWS = 8;

row_t rows [NUM_ROWS];

task automatic load_table();
	// key ar dr sr rr sl tl ks kcode pulses state rule att trend
	rows[0] = '{0, 31, 0, 0, 15, 4, 4, 0, 0, 3, eg_pkg::RELEASE, cmp_eq, 'h3ff, tr_any};
	rows[1] = '{1, 31, 0, 0, 15, 4, 4, 0, 0, 5, eg_pkg::DECAY, cmp_eq, 'h020, tr_any};
	rows[2] = '{1, 31, 31, 0, 15, 4, 4, 0, 0, 60, eg_pkg::SUSTAIN, cmp_ge, 'h0a0, tr_up};
	rows[3] = '{1, 31, 31, 0, 15, 4, 4, 0, 0, 40, eg_pkg::SUSTAIN, cmp_ge, 'h0a0, tr_flat};
	rows[4] = '{0, 31, 31, 0, 15, 4, 4, 0, 0, 400, eg_pkg::RELEASE, cmp_eq, 'h3ff, tr_up};
	rows[5] = '{1, 31, 31, 0, 15, 4, 127, 0, 0, 60, eg_pkg::SUSTAIN, cmp_eq, 'h3ff, tr_any};
	rows[6] = '{0, 31, 31, 0, 15, 4, 4, 0, 0, 400, eg_pkg::RELEASE, cmp_eq, 'h3ff, tr_any};
	rows[7] = '{1, 10, 0, 0, 15, 4, 4, 3, 31, 40, eg_pkg::ATTACK, cmp_le, 'h200, tr_down};
endtask

task automatic check_value(input string name, input logic [31:0] got,
	input logic [31:0] exp, input cmp_t cmp);
	logic ok;
	string op;
	ok = (cmp == cmp_le) ? (got <= exp) : (cmp == cmp_ge) ? (got >= exp) : (got == exp);
	op = (cmp == cmp_le) ? "<=" : (cmp == cmp_ge) ? ">=" : "==";
	if (!ok)
	begin
		errors++;
		$display("** Error: %s = 0x%0h, expected %s 0x%0h at %0t", name, got, op, exp, $time);
		abort_run();
	end
endtask

// returns on the falling edge where att_valid_o is seen high
task automatic wait_valid();
	int n;
	n = 0;
	@(negedge mclk);
	while (!att_valid)
	begin
		n++;
		if (n > VALID_TIMEOUT)
		begin
			$display("timed out waiting for att_valid_o at %0t", $time);
			abort_run();
		end
		@(negedge mclk);
	end
endtask

`endif

// File: tb_ym_eg_top.sv
// table-driven testbench for ym_eg_top, one att_valid_o pulse per envelope tick
// stops at the first mismatch or timeout
`timescale 1ns/1ps
`default_nettype none

module tb_ym_eg_top;

	localparam int VALID_TIMEOUT = 12; // clocks allowed between att_valid_o pulses

	logic mclk;
	logic arst_n;
	logic key_on;
	logic [4:0] ar;
	logic [4:0] dr;
	logic [4:0] sr;
	logic [3:0] rr;
	logic [4:0] sl;
	logic [6:0] tl;
	logic [1:0] ks;
	logic [4:0] kcode;
	logic [9:0] att;
	logic att_valid;
	eg_pkg::eg_state_t state;
	int errors;

	`include "tb_eg_util.svh"

	ym_eg_top u_ym_eg_top
		(
		.mclk_i      (mclk),
		.arst_n_i    (arst_n),
		.key_on_i    (key_on),
		.ar_i        (ar),
		.dr_i        (dr),
		.sr_i        (sr),
		.rr_i        (rr),
		.sl_i        (sl),
		.tl_i        (tl),
		.ks_i        (ks),
		.kcode_i     (kcode),
		.att_o       (att),
		.att_valid_o (att_valid),
		.state_o     (state)
		);

	initial
	begin
		mclk = 1'b0;
		forever #2 mclk = ~mclk;
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	// called on a falling edge, leaves on a falling edge
	task automatic run_row(input row_t r);
		logic [9:0] prev;
		int p;
		key_on = r.key_on;
		ar     = r.ar;
		dr     = r.dr;
		sr     = r.sr;
		rr     = r.rr;
		sl     = r.sl;
		tl     = r.tl;
		ks     = r.ks;
		kcode  = r.kcode;
		prev   = att;
		for (p = 0; p < r.pulses; p++)
		begin
			wait_valid();
			case (r.trend)
				tr_flat: check_value("att_o", 32'(att), 32'(prev), cmp_eq);
				tr_up:   check_value("att_o", 32'(att), 32'(prev), cmp_ge);
				tr_down: check_value("att_o", 32'(att), 32'(prev), cmp_le);
				default: ;
			endcase
			prev = att;
		end
		check_value("state_o", 32'(state), 32'(r.exp_state), cmp_eq);
		check_value("att_o", 32'(att), 32'(r.att_exp), r.att_cmp);
	endtask

	initial
	begin
		int i;
		errors = 0;
		arst_n = 1'b0;
		key_on = 1'b0;
		ar     = '0;
		dr     = '0;
		sr     = '0;
		rr     = '0;
		sl     = '0;
		tl     = '0;
		ks     = '0;
		kcode  = '0;
		load_table();
		repeat (3) @(posedge mclk);
		@(negedge mclk);
		arst_n = 1'b1;
		for (i = 0; i < NUM_ROWS; i++)
		begin
			$display("row %0d", i);
			run_row(rows[i]);
		end
		if (errors == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
			abort_run();
	end

endmodule

`default_nettype wire

// File: ym_eg_top.f
+incdir+.
eg_pkg.sv
eg_timer.sv
eg_rate.sv
eg_inc.sv
eg_env_state.sv
eg_atten_out.sv
ym_eg_top.sv
tb_ym_eg_top.sv

// File: ym_eg_top.sv
// single-operator envelope generator, register inputs assumed static between key events
// no SSG-EG, LFO AM, CSM or slot multiplexing
`timescale 1ns/1ps
`default_nettype none

module ym_eg_top
	(
	input  wire                            mclk_i,
	input  wire                            arst_n_i,
	input  wire                            key_on_i,
	input  wire  [eg_pkg::EG_RATE_W-1:0]   ar_i,
	input  wire  [eg_pkg::EG_RATE_W-1:0]   dr_i,
	input  wire  [eg_pkg::EG_RATE_W-1:0]   sr_i,
	input  wire  [eg_pkg::EG_RATE_W-2:0]   rr_i,
	input  wire  [eg_pkg::EG_RATE_W-1:0]   sl_i,
	input  wire  [6:0]                     tl_i,
	input  wire  [1:0]                     ks_i,
	input  wire  [4:0]                     kcode_i,
	output logic [eg_pkg::EG_LEVEL_W-1:0]  att_o,
	output logic                           att_valid_o,
	output eg_pkg::eg_state_t              state_o
	);

	logic tick;
	logic [3:0] cnt_shift;
	logic [1:0] cnt_phase;
	logic [eg_pkg::EG_EFF_W-1:0] eff_rate;
	logic step;
	eg_pkg::eg_amount_t amount;
	logic step_upd;
	logic [eg_pkg::EG_LEVEL_W-1:0] level;

	eg_timer u_eg_timer
		(
		.mclk_i      (mclk_i),
		.arst_n_i    (arst_n_i),
		.tick_o      (tick),
		.cnt_shift_o (cnt_shift),
		.cnt_phase_o (cnt_phase)
		);

	eg_rate u_eg_rate
		(
		.mclk_i     (mclk_i),
		.arst_n_i   (arst_n_i),
		.state_i    (state_o), // feedback from the state stage
		.ar_i       (ar_i),
		.dr_i       (dr_i),
		.sr_i       (sr_i),
		.rr_i       (rr_i),
		.ks_i       (ks_i),
		.kcode_i    (kcode_i),
		.eff_rate_o (eff_rate)
		);

	eg_inc u_eg_inc
		(
		.mclk_i      (mclk_i),
		.arst_n_i    (arst_n_i),
		.tick_i      (tick),
		.cnt_shift_i (cnt_shift),
		.cnt_phase_i (cnt_phase),
		.eff_rate_i  (eff_rate),
		.step_o      (step),
		.amount_o    (amount)
		);

	eg_env_state u_eg_env_state
		(
		.mclk_i     (mclk_i),
		.arst_n_i   (arst_n_i),
		.key_on_i   (key_on_i),
		.step_i     (step),
		.amount_i   (amount),
		.eff_rate_i (eff_rate),
		.sl_i       (sl_i),
		.state_o    (state_o),
		.level_o    (level)
		);

	// strobe aligned with the level register
	always_ff @(posedge mclk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			step_upd <= 1'b0;
		else
			step_upd <= step;
	end

	eg_atten_out u_eg_atten_out
		(
		.mclk_i      (mclk_i),
		.arst_n_i    (arst_n_i),
		.step_i      (step_upd),
		.level_i     (level),
		.tl_i        (tl_i),
		.att_o       (att_o),
		.att_valid_o (att_valid_o)
		);

endmodule

`default_nettype wire
